/* hdl/mini12_accumulator.sv */
// Accumulator and link of the mini12 processor
// Logical AND, two's-complement add and the group-1 operate bits
`timescale 1ns/100ps
`default_nettype none

module mini12_accumulator (
  input  logic              clock,
  input  logic              resetN,
  input  mini12_pkg::ctrl_t ctrl,
  input  mini12_pkg::word_t mb,
  input  mini12_pkg::word_t ir,
  output mini12_pkg::word_t ac,
  output logic              link
);
  import mini12_pkg::*;

  word_t ac_next;
  logic  link_next;
  word_t opr_ac;
  logic  opr_link;
  logic  carry;

  // Group 1 applies clear, then complement, then increment
  always_comb begin
    opr_ac   = ir[7] ? '0 : ac;
    opr_link = ir[6] ? 1'b0 : link;
    if (ir[5]) opr_ac = ~opr_ac;
    if (ir[4]) opr_link = ~opr_link;
    carry = 1'b0;
    if (ir[0]) {carry, opr_ac} = {1'b0, opr_ac} + 13'd1;
    opr_link = opr_link ^ carry;
  end

  always_comb begin
    ac_next   = ac;
    link_next = link;
    unique case (ctrl.ac_op)
      AC_CLEAR: ac_next = '0;
      AC_AND:   ac_next = ac & mb;
      AC_TAD:   begin
        {link_next, ac_next} = {1'b0, ac} + {1'b0, mb};
        link_next = link_next ^ link; // Carry out flips the link
      end
      AC_OPR:   {link_next, ac_next} = {opr_link, opr_ac};
      default:  ;
    endcase
  end

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      ac   <= '0;
      link <= 1'b0;
    end else begin
      ac   <= ac_next;
      link <= link_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/mini12_address_unit.sv */
// Address side of the mini12 datapath
// Holds PC, IR, the effective address and the memory address register
`timescale 1ns/100ps
`default_nettype none

module mini12_address_unit #(
  parameter mini12_pkg::addr_t RESET_PC = '0
) (
  input  logic              clock,
  input  logic              resetN,
  input  mini12_pkg::ctrl_t ctrl,
  input  mini12_pkg::word_t read_data,
  output mini12_pkg::word_t ir,
  output mini12_pkg::addr_t pc,
  output mini12_pkg::addr_t address
);
  import mini12_pkg::*;

  addr_t ea;
  addr_t direct_ea;

  // Page zero when bit 7 is clear, otherwise the page of the instruction
  assign direct_ea = {(ir[7] ? pc[11:7] : 5'b0), ir[6:0]};

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      pc      <= RESET_PC;
      ir      <= '0;
      ea      <= '0;
      address <= '0;
    end else begin
      if (ctrl.ir_load) ir <= read_data;
      unique case (ctrl.ea_op)
        EA_DIRECT: ea <= direct_ea;
        EA_READ:   ea <= read_data; // Pointer word
        default:   ;
      endcase
      unique case (ctrl.pc_op)
        PC_P1:   pc <= pc + 12'd1;
        PC_P2:   pc <= pc + 12'd2; // Skip taken
        PC_EA:   pc <= ea;
        PC_EAP1: pc <= ea + 12'd1;
        default: ;
      endcase
      unique case (ctrl.ad_sel)
        AD_PC:   address <= pc;
        AD_EA:   address <= ea;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/mini12_controller.sv */
// Control FSM of the mini12 processor
// Sequences fetch, effective address, decode and execute, one state per cycle
`timescale 1ns/100ps
`default_nettype none

module mini12_controller (
  input  logic                clock,
  input  logic                resetN,
  output mini12_pkg::ctrl_t   ctrl,
  input  mini12_pkg::status_t status,
  input  logic                run,
  output logic                read_enable,
  output logic                write_enable,
  output logic                halt
);
  import mini12_pkg::*;

  typedef enum logic [4:0] {
    S_INIT, S_IDLE, S_FETCH_1, S_FETCH_2, S_EA_DIR, S_EA_IND_1, S_EA_IND_2,
    S_DECODE, S_AND_1, S_AND_2, S_AND_3, S_TAD_1, S_TAD_2, S_TAD_3,
    S_ISZ_1, S_ISZ_2, S_ISZ_3, S_ISZ_4, S_ISZ_5, S_DCA_1, S_DCA_2, S_DCA_3,
    S_JMS_1, S_JMS_2, S_JMS_3, S_JMP_1, S_OPR_1, S_HALT
  } state_e;

  state_e  state, next_state;
  opcode_t opcode;

  assign opcode = status.ir[11:9];

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) state <= S_INIT;
    else         state <= next_state;
  end

  always_comb begin
    next_state = state;
    unique case (state)
      S_INIT:     next_state = S_IDLE;
      S_IDLE:     if (run) next_state = S_FETCH_1;
      S_FETCH_1:  next_state = S_FETCH_2;
      S_FETCH_2:  if (status.mem_finished) next_state = S_EA_DIR;
      S_EA_DIR:   begin
        // Operate and IOT words never take the indirect read
        if (status.ir[8] && opcode < 3'o6) next_state = S_EA_IND_1;
        else                               next_state = S_DECODE;
      end
      S_EA_IND_1: next_state = S_EA_IND_2;
      S_EA_IND_2: if (status.mem_finished) next_state = S_DECODE;
      S_DECODE:   begin
        if (status.ir == HALT_WORD) next_state = S_HALT;
        else begin
          case (opcode)
            3'o0:    next_state = S_AND_1;
            3'o1:    next_state = S_TAD_1;
            3'o2:    next_state = S_ISZ_1;
            3'o3:    next_state = S_DCA_1;
            3'o4:    next_state = S_JMS_1;
            3'o5:    next_state = S_JMP_1;
            default: next_state = S_OPR_1;
          endcase
        end
      end
      S_AND_1:    next_state = S_AND_2;
      S_AND_2:    if (status.mem_finished) next_state = S_AND_3;
      S_TAD_1:    next_state = S_TAD_2;
      S_TAD_2:    if (status.mem_finished) next_state = S_TAD_3;
      S_ISZ_1:    next_state = S_ISZ_2;
      S_ISZ_2:    if (status.mem_finished) next_state = S_ISZ_3;
      S_ISZ_3:    next_state = S_ISZ_4;
      S_ISZ_4:    if (status.mem_finished) next_state = S_ISZ_5;
      S_DCA_1:    next_state = S_DCA_2;
      S_DCA_2:    if (status.mem_finished) next_state = S_DCA_3;
      S_JMS_1:    next_state = S_JMS_2;
      S_JMS_2:    if (status.mem_finished) next_state = S_JMS_3;
      S_AND_3, S_TAD_3, S_ISZ_5, S_DCA_3, S_JMS_3, S_JMP_1, S_OPR_1, S_HALT:
                  next_state = S_IDLE;
      default:    next_state = S_INIT;
    endcase
  end

  always_comb begin
    ctrl.ac_op   = AC_NC;
    ctrl.pc_op   = PC_NC;
    ctrl.ea_op   = EA_NC;
    ctrl.mb_op   = MB_RD;   // Buffer follows read data on completion
    ctrl.ad_sel  = AD_NC;
    ctrl.wd_sel  = WD_AC;
    ctrl.ir_load = 1'b0;
    read_enable  = 1'b0;
    write_enable = 1'b0;
    halt         = 1'b0;
    unique case (state)
      S_INIT:     ctrl.ac_op = AC_CLEAR;
      S_FETCH_1:  ctrl.ad_sel = AD_PC;
      S_FETCH_2:  begin
        read_enable  = 1'b1;
        ctrl.ir_load = status.mem_finished;
      end
      S_EA_DIR:   ctrl.ea_op = EA_DIRECT;
      S_EA_IND_1: ctrl.ad_sel = AD_EA;
      S_EA_IND_2: begin
        read_enable = 1'b1;
        if (status.mem_finished) ctrl.ea_op = EA_READ; // Pointer becomes the address
      end
      S_AND_1, S_TAD_1, S_ISZ_1, S_DCA_1, S_JMS_1:
                  ctrl.ad_sel = AD_EA;
      S_AND_2, S_TAD_2, S_ISZ_2:
                  read_enable = 1'b1;
      S_AND_3:    begin
        ctrl.ac_op = AC_AND;
        ctrl.pc_op = PC_P1;
      end
      S_TAD_3:    begin
        ctrl.ac_op = AC_TAD;
        ctrl.pc_op = PC_P1;
      end
      S_ISZ_3:    ctrl.mb_op = MB_INC;
      S_ISZ_4:    begin
        ctrl.mb_op   = MB_NC;   // Hold the count while it is written back
        ctrl.wd_sel  = WD_MB;
        write_enable = 1'b1;
      end
      S_ISZ_5:    begin
        ctrl.mb_op = MB_NC;
        ctrl.pc_op = status.mb_zero ? PC_P2 : PC_P1;
      end
      S_DCA_2:    write_enable = 1'b1;
      S_DCA_3:    begin
        ctrl.ac_op = AC_CLEAR;
        ctrl.pc_op = PC_P1;
      end
      S_JMS_2:    begin
        ctrl.wd_sel  = WD_PCP1; // Return address
        write_enable = 1'b1;
      end
      S_JMS_3:    ctrl.pc_op = PC_EAP1;
      S_JMP_1:    ctrl.pc_op = PC_EA;
      S_OPR_1:    begin
        if (opcode == 3'o7 && !status.ir[8]) ctrl.ac_op = AC_OPR; // Group 1 only
        ctrl.pc_op = PC_P1;
      end
      S_HALT:     halt = 1'b1;
      default:    ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mini12_cpu.sv */
// Top level of the mini12 processor
// Connects the control FSM to the three datapath blocks and the memory port
`timescale 1ns/100ps
`default_nettype none

module mini12_cpu #(
  parameter mini12_pkg::addr_t RESET_PC = 12'o0200
) (
  input  logic                  clock,
  input  logic                  resetN,
  input  logic                  run,
  input  mini12_pkg::word_t     read_data,
  input  logic                  mem_finished,
  output mini12_pkg::mem_req_t  mem,
  output mini12_pkg::cpu_view_t view,
  output logic                  halt
);
  import mini12_pkg::*;

  ctrl_t   ctrl;
  status_t status;
  word_t   ir, mb, ac, write_data;
  addr_t   pc, address;
  logic    link, mb_zero, read_enable, write_enable;

  assign status = '{ir: ir, mb_zero: mb_zero, mem_finished: mem_finished};
  assign mem    = '{read_enable: read_enable, write_enable: write_enable,
                    address: address, write_data: write_data};
  assign view   = '{ac: ac, link: link, pc: pc};

  mini12_controller u_controller (.clock, .resetN, .ctrl, .status, .run,
                                  .read_enable, .write_enable, .halt);

  mini12_address_unit #(.RESET_PC(RESET_PC)) u_address_unit (
    .clock, .resetN, .ctrl, .read_data, .ir, .pc, .address);

  mini12_memory_buffer u_memory_buffer (.clock, .resetN, .ctrl, .read_data,
                                        .mem_finished, .ac, .pc, .mb, .mb_zero,
                                        .write_data);

  mini12_accumulator u_accumulator (.clock, .resetN, .ctrl, .mb, .ir, .ac, .link);

endmodule

`default_nettype wire

/* hdl/mini12_memory_buffer.sv */
// Memory buffer of the mini12 datapath
// Captures read data, increments for ISZ and selects the write data
`timescale 1ns/100ps
`default_nettype none

module mini12_memory_buffer (
  input  logic              clock,
  input  logic              resetN,
  input  mini12_pkg::ctrl_t ctrl,
  input  mini12_pkg::word_t read_data,
  input  logic              mem_finished,
  input  mini12_pkg::word_t ac,
  input  mini12_pkg::addr_t pc,
  output mini12_pkg::word_t mb,
  output logic              mb_zero,
  output mini12_pkg::word_t write_data
);
  import mini12_pkg::*;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) mb <= '0;
    else begin
      unique case (ctrl.mb_op)
        MB_RD:   if (mem_finished) mb <= read_data; // Data valid only on completion
        MB_INC:  mb <= mb + 12'd1;
        default: ;
      endcase
    end
  end

  assign mb_zero = (mb == '0);

  always_comb begin
    unique case (ctrl.wd_sel)
      WD_MB:   write_data = mb;
      WD_PCP1: write_data = word_t'(pc + 12'd1);
      default: write_data = ac;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/mini12_pkg.sv */
// Shared types for the mini12 accumulator processor
// Word types, datapath action codes and the structs between blocks
`default_nettype none

package mini12_pkg;

  typedef logic [11:0] word_t;   // One machine word
  typedef logic [11:0] addr_t;   // Word address
  typedef logic [2:0]  opcode_t; // Instruction bits 11 to 9

  localparam word_t HALT_WORD = 12'o7402;

  typedef enum logic [2:0] {
    AC_NC, AC_CLEAR, AC_AND, AC_TAD, AC_OPR
  } ac_op_e;

  typedef enum logic [2:0] {
    PC_NC, PC_P1, PC_P2, PC_EA, PC_EAP1
  } pc_op_e;

  typedef enum logic [1:0] {EA_NC, EA_DIRECT, EA_READ} ea_op_e;
  typedef enum logic [1:0] {MB_RD, MB_NC, MB_INC}      mb_op_e;
  typedef enum logic [1:0] {AD_NC, AD_PC, AD_EA}       ad_sel_e;
  typedef enum logic [1:0] {WD_AC, WD_MB, WD_PCP1}     wd_sel_e;

  typedef struct packed {
    ac_op_e  ac_op;
    pc_op_e  pc_op;
    ea_op_e  ea_op;
    mb_op_e  mb_op;
    ad_sel_e ad_sel;
    wd_sel_e wd_sel;
    logic    ir_load;
  } ctrl_t;

  typedef struct packed {
    word_t ir;
    logic  mb_zero;
    logic  mem_finished;
  } status_t;

  typedef struct packed {
    logic  read_enable;
    logic  write_enable;
    addr_t address;
    word_t write_data;
  } mem_req_t;

  typedef struct packed {
    word_t ac;
    logic  link;
    addr_t pc;
  } cpu_view_t;

endpackage

`default_nettype wire

/* mini12_cpu.f */
hdl/mini12_pkg.sv
hdl/mini12_controller.sv
hdl/mini12_accumulator.sv
hdl/mini12_address_unit.sv
hdl/mini12_memory_buffer.sv
hdl/mini12_cpu.sv
sim/mini12_tb_asserts.sv
sim/mini12_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the mini12 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module mini12_tb \
  -f mini12_cpu.f -o mini12_sim || exit 1
sim_output="$(./obj_dir/mini12_sim)"
echo "$sim_output"
echo "$sim_output" | grep -q "^Test completed successfully$" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* sim/mini12_tb.sv */
// Testbench for the mini12 processor
// Random programs run against an instruction-set model and a variable-latency memory
`timescale 1ns/100ps
`default_nettype none

module mini12_tb;
  import mini12_pkg::*;

  localparam int    CLK_PERIOD      = 40;
  localparam int    NUM_PROGS       = 6;
  localparam int    PROG_LEN        = 12;
  localparam int    TOTAL_INSTR     = NUM_PROGS * (PROG_LEN + 2) + 4;
  localparam int    WATCHDOG_CYCLES = 200 * TOTAL_INSTR + 100;
  localparam addr_t RESET_PC        = 12'o0200;

  logic      clock;
  logic      resetN;
  logic      run;
  word_t     read_data;
  logic      mem_finished;
  mem_req_t  mem_bus;
  cpu_view_t view;
  logic      halt;

  logic [31:0] lfsr_state = 32'h97268d3a;
  word_t memory [0:4095];        // Memory seen by the DUT
  word_t model_memory [0:4095];
  word_t model_ac;
  logic  model_link;
  addr_t model_pc;
  addr_t exp_addr [$];           // Writes the model predicts in program order
  word_t exp_data [$];
  int    wait_left = -1;         // Cycles until completion or -1 with no access open

  mini12_cpu #(.RESET_PC(RESET_PC)) UUT (
    .clock, .resetN, .run, .read_data, .mem_finished,
    .mem(mem_bus), .view, .halt);

  initial clock = 1'b0;
  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic logic lfsr_next();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic word_t rand_bits(int n);
    word_t r;
    r = '0;
    for (int i = 0; i < n; i++) r = {r[10:0], lfsr_next()};
    return r;
  endfunction

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_word(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_addr(string name, addr_t actual, addr_t expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic compare_bit(string name, logic actual, logic expected);
    if (actual !== expected) begin
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
      abort_run();
    end
  endtask

  task automatic store_word(addr_t a, word_t w);
    memory[a]       = w;
    model_memory[a] = w;
  endtask

  // Page zero or current page, then one pointer read for bit 8
  function automatic addr_t operand_address(word_t instr, addr_t at);
    addr_t a;
    a = {(instr[7] ? at[11:7] : 5'b0), instr[6:0]};
    if (instr[8]) a = model_memory[a];
    return a;
  endfunction

  task automatic model_write(addr_t a, word_t v);
    model_memory[a] = v;
    exp_addr.push_back(a);
    exp_data.push_back(v);
  endtask

  // Runs the model from its PC up to the next HLT
  task automatic model_run();
    word_t       instr;
    addr_t       ea;
    word_t       value;
    logic [12:0] sum;
    int          steps;
    steps = 0;
    instr = model_memory[model_pc];
    while (instr != HALT_WORD) begin
      ea = (instr[11:9] < 3'o6) ? operand_address(instr, model_pc) : '0;
      case (instr[11:9])
        3'o0: model_ac = model_ac & model_memory[ea];
        3'o1: begin
          sum        = {1'b0, model_ac} + {1'b0, model_memory[ea]};
          model_ac   = sum[11:0];
          model_link = model_link ^ sum[12];
        end
        3'o2: begin
          value = model_memory[ea] + 12'd1;
          model_write(ea, value);
          if (value == 12'd0) model_pc = model_pc + 12'd1;   // Skip
        end
        3'o3: begin
          model_write(ea, model_ac);
          model_ac = '0;
        end
        3'o4: model_write(ea, model_pc + 12'd1);
        3'o7: begin
          if (!instr[8]) begin
            if (instr[7]) model_ac = '0;
            if (instr[6]) model_link = 1'b0;
            if (instr[5]) model_ac = ~model_ac;
            if (instr[4]) model_link = ~model_link;
            if (instr[0]) begin
              sum        = {1'b0, model_ac} + 13'd1;
              model_ac   = sum[11:0];
              model_link = model_link ^ sum[12];
            end
          end
        end
        default: ;                                             // JMP and IOT leave AC alone
      endcase
      if (instr[11:9] == 3'o4) model_pc = ea + 12'd1;
      else if (instr[11:9] == 3'o5) model_pc = ea;
      else model_pc = model_pc + 12'd1;
      steps++;
      if (steps > 2 * PROG_LEN + 8) begin
        $display("The instruction-set model ran too long without reaching HLT");
        abort_run();
      end
      instr = model_memory[model_pc];
    end
  endtask

  // Memory references pick data or pointer areas; the rest are operate and IOT words
  function automatic word_t random_instr();
    word_t      kind;
    word_t      r;
    word_t      w;
    logic [6:0] offset;
    kind = rand_bits(3);
    r    = rand_bits(9);
    case (kind[2:0])
      3'd4, 3'd5: w = {3'o7, 1'b0, r[7:0]};                 // Group 1
      3'd6:       w = {3'o6, r[8:0]};
      3'd7: begin
        w = {3'o7, 1'b1, r[7:0]};
        if (w == HALT_WORD) w = 12'o7400;
      end
      default: begin
        if (r[8]) offset = r[7] ? {3'b111, r[3:0]} : {3'b000, r[3:0]};
        else offset = r[7] ? {3'b110, r[3:0]} : 7'o040 + {1'b0, r[5:0]};
        w = {kind[2:0], r[8], r[7], offset};
      end
    endcase
    return w;
  endfunction

  task automatic gen_program();
    addr_t at;
    word_t w;
    word_t r;
    at = model_pc;
    for (int i = 0; i < PROG_LEN; i++) begin
      w = random_instr();
      store_word(at, w);
      r = rand_bits(1);
      if (w[11:9] == 3'o2 && r[0] == 1'b0) store_word(operand_address(w, at), 12'o7777);
      at = at + 12'd1;
    end
    store_word(at, HALT_WORD);
    store_word(at + 12'd1, HALT_WORD);   // Landing spot if the last ISZ skips
  endtask

  // One clock of the memory responder at each rising edge
  task automatic memory_cycle();
    word_t r;
    if (mem_finished) begin
      mem_finished <= 1'b0;
      read_data    <= 12'o5252;
    end else if (mem_bus.read_enable || mem_bus.write_enable) begin
      if (wait_left < 0) begin
        r         = rand_bits(2);
        wait_left = int'(r[1:0]);
      end
      if (wait_left == 0) begin
        if (mem_bus.write_enable) begin
          if (exp_addr.size() == 0) begin
            $display("The DUT wrote to memory when the model expected no write");
            abort_run();
          end
          compare_addr("address", mem_bus.address, exp_addr.pop_front());
          compare_word("write_data", mem_bus.write_data, exp_data.pop_front());
          memory[mem_bus.address] = mem_bus.write_data;
        end else read_data <= memory[mem_bus.address];
        mem_finished <= 1'b1;
        wait_left    = -1;
      end else wait_left--;
    end
  endtask

  task automatic check_quiet(int cycles);
    repeat (cycles) begin
      @(posedge clock);
      compare_bit("read_enable", mem_bus.read_enable, 1'b0);
      compare_bit("write_enable", mem_bus.write_enable, 1'b0);
      compare_bit("halt", halt, 1'b0);
    end
  endtask

  task automatic run_program();
    model_run();
    run <= 1'b1;
    do begin
      @(posedge clock);
      memory_cycle();
    end while (!halt);
    run <= 1'b0;                          // Dropped in the halt cycle
    compare_word("ac", view.ac, model_ac);
    compare_bit("link", view.link, model_link);
    compare_addr("pc", view.pc, model_pc);
    if (exp_addr.size() != 0) begin
      $display("The DUT halted before making all the writes the model expects");
      abort_run();
    end
    check_quiet(4);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles with the run unfinished", WATCHDOG_CYCLES);
    abort_run();
  end

  initial begin
    addr_t a;
    addr_t caller;
    resetN       <= 1'b0;
    run          <= 1'b0;
    read_data    <= '0;
    mem_finished <= 1'b0;
    for (int i = 0; i < 4096; i++) begin
      a = addr_t'(i);
      if (a < 12'o0020 || (a >= 12'o0360 && a <= 12'o0377))
        store_word(a, 12'o2000 | {4'b0, a[3:0], a[7:4]});  // Pointers into 2000-2377
      else
        store_word(a, {a[5:0], a[11:6]} ^ 12'o2525);
    end
    model_ac   = '0;
    model_link = 1'b0;
    model_pc   = RESET_PC;

    repeat (4) @(posedge clock);
    resetN <= 1'b1;
    repeat (2) @(posedge clock);          // Init state, then idle
    compare_word("ac", view.ac, 12'o0000);
    compare_bit("link", view.link, 1'b0);
    compare_addr("pc", view.pc, RESET_PC);
    check_quiet(4);

    repeat (NUM_PROGS) begin
      gen_program();
      run_program();
    end

    // Subroutine call through page zero and return through its link word
    caller = model_pc;
    store_word(12'o0020, 12'o0000);
    store_word(12'o0021, 12'o1040);       // TAD 0040
    store_word(12'o0022, 12'o5420);       // JMP I 0020
    store_word(caller, 12'o4020);         // JMS 0020
    store_word(caller + 12'd1, HALT_WORD);
    run_program();
    compare_word("return word", memory[12'o0020], caller + 12'd1);
    compare_addr("pc", view.pc, caller + 12'd1);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/mini12_tb_asserts.sv */
// Protocol checks on the mini12 control FSM
// Strobe exclusion, strobe hold until completion and a quiet halt around reset
`timescale 1ns/100ps
`default_nettype none

module mini12_tb_asserts (
  input logic                clock,
  input logic                resetN,
  input mini12_pkg::status_t status,
  input logic                read_enable,
  input logic                write_enable,
  input logic                halt
);

  strobes_exclusive: assert property (@(posedge clock) disable iff (!resetN)
    !(read_enable && write_enable))
    else $error("Read and write strobes are active together");

  read_held: assert property (@(posedge clock) disable iff (!resetN)
    read_enable && !status.mem_finished |=> read_enable)
    else $error("Read strobe dropped before mem_finished");

  write_held: assert property (@(posedge clock) disable iff (!resetN)
    write_enable && !status.mem_finished |=> write_enable)
    else $error("Write strobe dropped before mem_finished");

  halt_in_reset: assert property (@(posedge clock) !resetN |-> !halt)
    else $error("halt is high during reset");

  halt_after_reset: assert property (@(posedge clock) !resetN |=> !halt)
    else $error("halt is high right after reset");

endmodule

bind mini12_controller mini12_tb_asserts u_asserts (
  .clock(clock),
  .resetN(resetN),
  .status(status),
  .read_enable(read_enable),
  .write_enable(write_enable),
  .halt(halt)
);

`default_nettype wire
